//--- axi_rd_pkg.sv
package axi_rd_pkg;

	// Bus is fixed at 64 bits, size and offset fields depend on it
	localparam int DATA_W = 64;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [3:0]        id_t;
	typedef logic [7:0]        len_t;      // Beats minus one
	typedef logic [1:0]        cpu_size_t; // 0:1B 1:2B 2:4B 3:8B
	typedef logic [2:0]        axsize_t;
	typedef logic [1:0]        burst_t;
	typedef logic [1:0]        resp_t;

	localparam burst_t BURST_INCR  = 2'b01;
	localparam resp_t  RESP_OKAY   = 2'b00;
	localparam resp_t  RESP_SLVERR = 2'b10;

	// Ones over the access width, moved up to the byte lane of the offset
	function automatic data_t lane_mask(
		input cpu_size_t size,
		input logic [2:0] offset
	);
		data_t base;
		case (size)
			2'd0: base = {56'h0, 8'hff};
			2'd1: base = {48'h0, 16'hffff};
			2'd2: base = {32'h0, 32'hffff_ffff};
			default: base = '1;
		endcase
		return base << {offset, 3'b000}; // Upper bytes fall off the top
	endfunction

endpackage

//--- rd_req_if.sv
`timescale 1ns/1ps

interface rd_req_if #(
	parameter int ADDR_W = 32
) ();
	import axi_rd_pkg::*;

	logic              req_valid;  // Level while a burst is owned
	id_t               req_id;
	logic [ADDR_W-1:0] req_addr;   // 8-byte aligned
	logic [2:0]        req_offset; // Original low address bits
	len_t              req_len;
	cpu_size_t         req_size;
	logic              req_done;   // One cycle, after the last R beat

	modport latch (
		output req_valid, req_id, req_addr, req_offset, req_len, req_size,
		input  req_done
	);

	modport master (
		input  req_valid, req_id, req_addr, req_len, req_size,
		output req_done
	);

	modport align (
		input req_offset, req_size
	);

endinterface

//--- rd_beat_if.sv
`timescale 1ns/1ps

interface rd_beat_if;
	import axi_rd_pkg::*;

	// One pulse per accepted R transfer
	logic  beat_valid;
	data_t beat_data;
	resp_t beat_resp;
	logic  beat_last;

	modport master (
		output beat_valid, beat_data, beat_resp, beat_last
	);

	modport align (
		input beat_valid, beat_data, beat_resp, beat_last
	);

endinterface

//--- rd_req_latch.sv
`timescale 1ns/1ps

module rd_req_latch #(
	parameter int ADDR_W = 32
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  cpu_ar_valid_i,
	input  axi_rd_pkg::id_t       cpu_id_i,
	input  logic [ADDR_W-1:0]     cpu_addr_i,
	input  axi_rd_pkg::len_t      cpu_len_i,
	input  axi_rd_pkg::cpu_size_t cpu_size_i,
	output logic                  cpu_ar_ready_o,
	rd_req_if.latch               req
);
	import axi_rd_pkg::*;

	logic      busy;
	logic      accept;
	id_t       id_q;
	len_t      len_q;
	cpu_size_t size_q;

	assign accept = cpu_ar_valid_i && !busy;

	// Held from acceptance until the master reports the last beat
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end else if (req.req_done) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			id_q           <= cpu_id_i;
			len_q          <= cpu_len_i;
			size_q         <= cpu_size_i;
			req.req_addr   <= {cpu_addr_i[ADDR_W-1:3], 3'b000}; // Beat aligned
			req.req_offset <= cpu_addr_i[2:0];
		end
	end

	assign req.req_valid  = busy;
	assign req.req_id     = id_q;
	assign req.req_len    = len_q;
	assign req.req_size   = size_q;

	assign cpu_ar_ready_o = !busy; // Ready only while idle

endmodule

//--- axi_ar_r_master.sv
`timescale 1ns/1ps

module axi_ar_r_master #(
	parameter int ADDR_W = 32
) (
	input  logic                clk,
	input  logic                reset_n,
	rd_req_if.master            req,
	rd_beat_if.master           beat,
	input  logic                axi_ar_ready_i,
	output logic                axi_ar_valid_o,
	output axi_rd_pkg::id_t     axi_ar_id_o,
	output logic [ADDR_W-1:0]   axi_ar_addr_o,
	output axi_rd_pkg::len_t    axi_ar_len_o,
	output axi_rd_pkg::axsize_t axi_ar_size_o,
	output axi_rd_pkg::burst_t  axi_ar_burst_o,
	output logic [2:0]          axi_ar_prot_o,
	output logic                axi_ar_lock_o,
	output logic [3:0]          axi_ar_cache_o,
	output logic [3:0]          axi_ar_qos_o,
	output logic [3:0]          axi_ar_region_o,
	input  logic                axi_r_valid_i,
	input  axi_rd_pkg::data_t   axi_r_data_i,
	input  axi_rd_pkg::resp_t   axi_r_resp_i,
	input  logic                axi_r_last_i,
	input  axi_rd_pkg::id_t     axi_r_id_i, // Only one burst in flight, so unchecked
	output logic                axi_r_ready_o
);
	import axi_rd_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA
	} rd_state_t;

	rd_state_t state;
	rd_state_t state_n;
	logic      ar_hs;
	logic      r_hs;
	logic      r_done;
	logic      done_q;
	logic      ar_valid_q;

	assign ar_hs  = ar_valid_q && axi_ar_ready_i;
	assign r_hs   = axi_r_valid_i && axi_r_ready_o;
	assign r_done = r_hs && axi_r_last_i;

	always_comb begin
		state_n = state;
		case (state)
			IDLE: begin
				// req_valid is still up the cycle done is out
				if (req.req_valid && !done_q) begin
					state_n = ADDR;
				end
			end
			ADDR: begin
				if (ar_hs) begin
					state_n = DATA;
				end
			end
			DATA: begin
				if (r_done) begin
					state_n = IDLE;
				end
			end
			default: state_n = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state      <= IDLE;
			ar_valid_q <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			state      <= state_n;
			ar_valid_q <= (state_n == ADDR);
			done_q     <= r_done; // Lets the latch drop busy
		end
	end

	// Fields load on leaving IDLE and stay put through ADDR
	always_ff @(posedge clk) begin
		if (state == IDLE && state_n == ADDR) begin
			axi_ar_id_o   <= req.req_id;
			axi_ar_addr_o <= req.req_addr;
			axi_ar_len_o  <= req.req_len;
			axi_ar_size_o <= axsize_t'({1'b0, req.req_size});
		end
	end

	assign axi_ar_valid_o  = ar_valid_q;
	assign axi_ar_burst_o  = BURST_INCR;
	assign axi_ar_prot_o   = 3'd0;
	assign axi_ar_lock_o   = 1'b0;
	assign axi_ar_cache_o  = 4'd0;
	assign axi_ar_qos_o    = 4'd0;
	assign axi_ar_region_o = 4'd0;

	assign axi_r_ready_o   = (state == DATA);

	// Beats go straight through, the aligner registers them
	assign beat.beat_valid = r_hs;
	assign beat.beat_data  = axi_r_data_i;
	assign beat.beat_resp  = axi_r_resp_i;
	assign beat.beat_last  = axi_r_last_i;

	assign req.req_done    = done_q;

endmodule

//--- rd_data_align.sv
`timescale 1ns/1ps

module rd_data_align (
	input  logic              clk,
	input  logic              reset_n,
	rd_req_if.align           req,
	rd_beat_if.align          beat,
	output logic              cpu_r_valid_o,
	output axi_rd_pkg::data_t cpu_r_data_o,
	output axi_rd_pkg::resp_t cpu_r_resp_o,
	output logic              cpu_r_last_o
);
	import axi_rd_pkg::*;

	data_t mask;
	data_t data_masked;
	logic  valid_q;
	data_t data_q;
	resp_t resp_q;
	logic  last_q;

	// Same mask for every beat of the burst
	assign mask        = lane_mask(req.req_size, req.req_offset);
	assign data_masked = beat.beat_data & mask; // Bytes stay in their lanes

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= beat.beat_valid; // One pulse per beat
		end
	end

	always_ff @(posedge clk) begin
		if (beat.beat_valid) begin
			data_q <= data_masked;
			resp_q <= beat.beat_resp;
			last_q <= beat.beat_last;
		end
	end

	assign cpu_r_valid_o = valid_q;
	assign cpu_r_data_o  = data_q;
	assign cpu_r_resp_o  = resp_q;
	assign cpu_r_last_o  = last_q;

endmodule

//--- axi_rd_bridge_top.sv
`timescale 1ns/1ps

module axi_rd_bridge_top #(
	parameter int ADDR_W = 32
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  cpu_ar_valid_i,
	input  axi_rd_pkg::id_t       cpu_id_i,
	input  logic [ADDR_W-1:0]     cpu_addr_i,
	input  axi_rd_pkg::len_t      cpu_len_i,
	input  axi_rd_pkg::cpu_size_t cpu_size_i,
	output logic                  cpu_ar_ready_o,
	output logic                  cpu_r_valid_o,
	output axi_rd_pkg::data_t     cpu_r_data_o,
	output axi_rd_pkg::resp_t     cpu_r_resp_o,
	output logic                  cpu_r_last_o,
	input  logic                  axi_ar_ready_i,
	output logic                  axi_ar_valid_o,
	output axi_rd_pkg::id_t       axi_ar_id_o,
	output logic [ADDR_W-1:0]     axi_ar_addr_o,
	output axi_rd_pkg::len_t      axi_ar_len_o,
	output axi_rd_pkg::axsize_t   axi_ar_size_o,
	output axi_rd_pkg::burst_t    axi_ar_burst_o,
	output logic [2:0]            axi_ar_prot_o,
	output logic                  axi_ar_lock_o,
	output logic [3:0]            axi_ar_cache_o,
	output logic [3:0]            axi_ar_qos_o,
	output logic [3:0]            axi_ar_region_o,
	input  logic                  axi_r_valid_i,
	input  axi_rd_pkg::data_t     axi_r_data_i,
	input  axi_rd_pkg::resp_t     axi_r_resp_i,
	input  logic                  axi_r_last_i,
	input  axi_rd_pkg::id_t       axi_r_id_i,
	output logic                  axi_r_ready_o
);

	rd_req_if #(.ADDR_W(ADDR_W)) req_if ();
	rd_beat_if                   beat_if ();

	rd_req_latch #(.ADDR_W(ADDR_W)) i_rd_req_latch (
		.clk           (clk),
		.reset_n       (reset_n),
		.cpu_ar_valid_i(cpu_ar_valid_i),
		.cpu_id_i      (cpu_id_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_len_i     (cpu_len_i),
		.cpu_size_i    (cpu_size_i),
		.cpu_ar_ready_o(cpu_ar_ready_o),
		.req           (req_if.latch)
	);

	axi_ar_r_master #(.ADDR_W(ADDR_W)) i_axi_ar_r_master (
		.clk            (clk),
		.reset_n        (reset_n),
		.req            (req_if.master),
		.beat           (beat_if.master),
		.axi_ar_ready_i (axi_ar_ready_i),
		.axi_ar_valid_o (axi_ar_valid_o),
		.axi_ar_id_o    (axi_ar_id_o),
		.axi_ar_addr_o  (axi_ar_addr_o),
		.axi_ar_len_o   (axi_ar_len_o),
		.axi_ar_size_o  (axi_ar_size_o),
		.axi_ar_burst_o (axi_ar_burst_o),
		.axi_ar_prot_o  (axi_ar_prot_o),
		.axi_ar_lock_o  (axi_ar_lock_o),
		.axi_ar_cache_o (axi_ar_cache_o),
		.axi_ar_qos_o   (axi_ar_qos_o),
		.axi_ar_region_o(axi_ar_region_o),
		.axi_r_valid_i  (axi_r_valid_i),
		.axi_r_data_i   (axi_r_data_i),
		.axi_r_resp_i   (axi_r_resp_i),
		.axi_r_last_i   (axi_r_last_i),
		.axi_r_id_i     (axi_r_id_i),
		.axi_r_ready_o  (axi_r_ready_o)
	);

	rd_data_align i_rd_data_align (
		.clk          (clk),
		.reset_n      (reset_n),
		.req          (req_if.align),
		.beat         (beat_if.align),
		.cpu_r_valid_o(cpu_r_valid_o),
		.cpu_r_data_o (cpu_r_data_o),
		.cpu_r_resp_o (cpu_r_resp_o),
		.cpu_r_last_o (cpu_r_last_o)
	);

endmodule

//--- tb_axi_mem_model.sv
`timescale 1ns/1ps

module tb_axi_mem_model #(
	parameter integer SEED    = 32'hf0eeaa1c,
	parameter int     TIMEOUT = 300
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              rnd_delay_i, // 0 to 3 cycle ready delays when set
	input  logic              ar_valid_i,
	input  axi_rd_pkg::id_t   ar_id_i,
	input  logic [31:0]       ar_addr_i,
	input  axi_rd_pkg::len_t  ar_len_i,
	output logic              ar_ready_o,
	output logic              r_valid_o,
	output axi_rd_pkg::data_t r_data_o,
	output axi_rd_pkg::resp_t r_resp_o,
	output logic              r_last_o,
	output axi_rd_pkg::id_t   r_id_o,
	input  logic              r_ready_i
);
	import axi_rd_pkg::*;

	integer      seed;
	logic [31:0] base;
	logic [31:0] b;
	len_t        len;
	id_t         id;
	int          k;
	int          t;

	function automatic int pick_delay();
		return rnd_delay_i ? int'($unsigned($random(seed)) % 4) : 0;
	endfunction

	// Leaves the caller 1 ns after an edge
	task wait_edges(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		seed       = SEED;
		ar_ready_o = 1'b0;
		r_valid_o  = 1'b0;
		r_data_o   = '0;
		r_resp_o   = RESP_OKAY;
		r_last_o   = 1'b0;
		r_id_o     = '0;
		forever begin
			@(posedge clk);
			if (reset_n && ar_valid_i) begin
				#1;
				wait_edges(pick_delay());
				ar_ready_o = 1'b1;
				@(posedge clk); // AR handshake, valid is held by the master
				base = {ar_addr_i[31:3], 3'b000};
				len  = ar_len_i;
				id   = ar_id_i;
				#1;
				ar_ready_o = 1'b0;
				for (k = 0; k <= len; k++) begin
					wait_edges(pick_delay());
					b         = base + 32'(8 * k);
					r_valid_o = 1'b1;
					r_data_o  = {b ^ 32'h5a5a0000, ~b};
					r_resp_o  = b[31] ? RESP_SLVERR : RESP_OKAY;
					r_last_o  = (k == len);
					r_id_o    = id;
					t = 0;
					@(posedge clk);
					while (!r_ready_i && t < TIMEOUT) begin
						@(posedge clk);
						t++;
					end
					#1;
					r_valid_o = 1'b0;
					r_last_o  = 1'b0;
				end
			end
		end
	end

endmodule

//--- axi_rd_bridge_sva.sv
`timescale 1ns/1ps

module axi_rd_bridge_sva #(
	parameter int ADDR_W = 32
) (
	input logic                clk,
	input logic                reset_n,
	input logic                cpu_ar_valid_i,
	input logic                cpu_ar_ready_o,
	input logic                cpu_r_valid_o,
	input logic                cpu_r_last_o,
	input logic                axi_ar_valid_o,
	input logic                axi_ar_ready_i,
	input axi_rd_pkg::id_t     axi_ar_id_o,
	input logic [ADDR_W-1:0]   axi_ar_addr_o,
	input axi_rd_pkg::len_t    axi_ar_len_o,
	input axi_rd_pkg::axsize_t axi_ar_size_o,
	input logic                axi_r_valid_i,
	input logic                axi_r_ready_o
);

	logic r_hs;
	logic in_burst; // From acceptance up to the last CPU beat
	int   assert_fails = 0;

	assign r_hs = axi_r_valid_i && axi_r_ready_o;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			in_burst <= 1'b0;
		end else if (cpu_ar_valid_i && cpu_ar_ready_o) begin
			in_burst <= 1'b1;
		end else if (cpu_r_valid_o && cpu_r_last_o) begin
			in_burst <= 1'b0;
		end
	end

	ar_held: assert property (@(posedge clk) disable iff (!reset_n)
		axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o)
			&& $stable(axi_ar_id_o) && $stable(axi_ar_len_o) && $stable(axi_ar_size_o))
		else begin
			$error("AR request changed or dropped before the slave took it");
			assert_fails++;
		end

	ar_r_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(axi_r_ready_o && axi_ar_valid_o))
		else begin
			$error("R ready raised while the AR request is still pending");
			assert_fails++;
		end

	cpu_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_r_valid_o && $past(cpu_r_valid_o) |-> $past(r_hs) && $past(r_hs, 2))
		else begin
			$error("CPU response valid held without back to back R transfers");
			assert_fails++;
		end

	ready_blocked: assert property (@(posedge clk) disable iff (!reset_n)
		in_burst |-> !cpu_ar_ready_o)
		else begin
			$error("CPU request ready came back before the last beat");
			assert_fails++;
		end

endmodule

bind axi_rd_bridge_top axi_rd_bridge_sva #(.ADDR_W(ADDR_W)) i_axi_rd_bridge_sva (
	.clk           (clk),
	.reset_n       (reset_n),
	.cpu_ar_valid_i(cpu_ar_valid_i),
	.cpu_ar_ready_o(cpu_ar_ready_o),
	.cpu_r_valid_o (cpu_r_valid_o),
	.cpu_r_last_o  (cpu_r_last_o),
	.axi_ar_valid_o(axi_ar_valid_o),
	.axi_ar_ready_i(axi_ar_ready_i),
	.axi_ar_id_o   (axi_ar_id_o),
	.axi_ar_addr_o (axi_ar_addr_o),
	.axi_ar_len_o  (axi_ar_len_o),
	.axi_ar_size_o (axi_ar_size_o),
	.axi_r_valid_i (axi_r_valid_i),
	.axi_r_ready_o (axi_r_ready_o)
);

//--- tb_axi_rd_bridge.sv
`timescale 1ns/1ps

module tb_axi_rd_bridge;
	import axi_rd_pkg::*;

	localparam int     ADDR_W  = 32;
	localparam int     TIMEOUT = 300; // Cycles per wait
	localparam integer SEED    = 32'hf0eeaa1c;
	localparam int     W_READY = 0;
	localparam int     W_AR    = 1;
	localparam int     W_DRAIN = 2;

	logic              clk;
	logic              reset_n;
	logic              cpu_ar_valid;
	id_t               cpu_id;
	logic [ADDR_W-1:0] cpu_addr;
	len_t              cpu_len;
	cpu_size_t         cpu_size;
	logic              cpu_ar_ready;
	logic              cpu_r_valid;
	data_t             cpu_r_data;
	resp_t             cpu_r_resp;
	logic              cpu_r_last;
	logic              ar_ready;
	logic              ar_valid;
	id_t               ar_id;
	logic [ADDR_W-1:0] ar_addr;
	len_t              ar_len;
	axsize_t           ar_size;
	burst_t            ar_burst;
	logic [2:0]        ar_prot;
	logic              ar_lock;
	logic [3:0]        ar_cache;
	logic [3:0]        ar_qos;
	logic [3:0]        ar_region;
	logic              r_valid;
	data_t             r_data;
	resp_t             r_resp;
	logic              r_last;
	id_t               r_id;
	logic              r_ready;

	integer seed;
	logic   delay_en;
	string  test_name;
	int     err_cnt;
	int     err_start;
	int     pass_cnt;
	int     fail_cnt;
	int     beat_cnt;
	data_t  exp_data_q[$];
	resp_t  exp_resp_q[$];
	logic   exp_last_q[$];

	always #5 clk = ~clk;

	axi_rd_bridge_top #(.ADDR_W(ADDR_W)) i_axi_rd_bridge_top (
		.clk(clk), .reset_n(reset_n),
		.cpu_ar_valid_i(cpu_ar_valid), .cpu_id_i(cpu_id), .cpu_addr_i(cpu_addr),
		.cpu_len_i(cpu_len), .cpu_size_i(cpu_size), .cpu_ar_ready_o(cpu_ar_ready),
		.cpu_r_valid_o(cpu_r_valid), .cpu_r_data_o(cpu_r_data),
		.cpu_r_resp_o(cpu_r_resp), .cpu_r_last_o(cpu_r_last),
		.axi_ar_ready_i(ar_ready), .axi_ar_valid_o(ar_valid), .axi_ar_id_o(ar_id),
		.axi_ar_addr_o(ar_addr), .axi_ar_len_o(ar_len), .axi_ar_size_o(ar_size),
		.axi_ar_burst_o(ar_burst), .axi_ar_prot_o(ar_prot), .axi_ar_lock_o(ar_lock),
		.axi_ar_cache_o(ar_cache), .axi_ar_qos_o(ar_qos), .axi_ar_region_o(ar_region),
		.axi_r_valid_i(r_valid), .axi_r_data_i(r_data), .axi_r_resp_i(r_resp),
		.axi_r_last_i(r_last), .axi_r_id_i(r_id), .axi_r_ready_o(r_ready)
	);

	tb_axi_mem_model #(.SEED(SEED), .TIMEOUT(TIMEOUT)) i_mem_model (
		.clk(clk), .reset_n(reset_n), .rnd_delay_i(delay_en),
		.ar_valid_i(ar_valid), .ar_id_i(ar_id), .ar_addr_i(ar_addr), .ar_len_i(ar_len),
		.ar_ready_o(ar_ready), .r_valid_o(r_valid), .r_data_o(r_data),
		.r_resp_o(r_resp), .r_last_o(r_last), .r_id_o(r_id), .r_ready_i(r_ready)
	);

	// Pattern of beat k seen through the lanes of the request
	function automatic data_t expect_beat(input logic [31:0] addr, input cpu_size_t size,
		input int k);
		logic [31:0] b;
		data_t       pattern;
		b       = {addr[31:3], 3'b000} + 32'(8 * k);
		pattern = {b ^ 32'h5a5a0000, ~b};
		return pattern & lane_mask(size, addr[2:0]);
	endfunction

	task check_val(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			err_cnt++;
		end
	endtask

	function automatic logic cond_met(input int sel);
		case (sel)
			W_READY: return cpu_ar_ready === 1'b1;
			W_AR:    return ar_valid === 1'b1;
			default: return exp_data_q.size() == 0;
		endcase
	endfunction

	task wait_cond(input int sel, input string what);
		int t;
		t = 0;
		while (!cond_met(sel) && t < TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		if (!cond_met(sel)) begin
			$display("ERROR: test %s gave up waiting for %s", test_name, what);
			$display("Regression failed");
			$finish;
		end
	endtask

	task issue_read(input logic [31:0] addr, input len_t len, input cpu_size_t size);
		logic [31:0] b;
		id_t         id;
		int          k;
		id       = id_t'($random(seed));
		beat_cnt = 0;
		for (k = 0; k <= len; k++) begin
			b = {addr[31:3], 3'b000} + 32'(8 * k);
			exp_data_q.push_back(expect_beat(addr, size, k));
			exp_resp_q.push_back(b[31] ? RESP_SLVERR : RESP_OKAY);
			exp_last_q.push_back(k == len);
		end
		wait_cond(W_READY, "request ready");
		cpu_ar_valid = 1'b1;
		cpu_id       = id;
		cpu_addr     = addr;
		cpu_len      = len;
		cpu_size     = size;
		@(posedge clk);
		#1;
		cpu_ar_valid = 1'b0;
		check_val({test_name, " ready after accept"}, 0, cpu_ar_ready);
		wait_cond(W_AR, "AR valid");
		check_val({test_name, " ar_addr"}, {addr[31:3], 3'b000}, ar_addr);
		check_val({test_name, " ar_len"}, len, ar_len);
		check_val({test_name, " ar_size"}, {1'b0, size}, ar_size);
		check_val({test_name, " ar_burst"}, BURST_INCR, ar_burst);
		check_val({test_name, " ar_id"}, id, ar_id);
		// Sideband fields all tied off
		check_val({test_name, " ar_prot"}, 0, ar_prot);
		check_val({test_name, " ar_lock"}, 0, ar_lock);
		check_val({test_name, " ar_cache"}, 0, ar_cache);
		check_val({test_name, " ar_qos"}, 0, ar_qos);
		check_val({test_name, " ar_region"}, 0, ar_region);
		wait_cond(W_DRAIN, "all response beats");
		wait_cond(W_READY, "request ready after the burst");
		check_val({test_name, " beat count"}, len + 1, beat_cnt);
	endtask

	task random_read(input logic [31:0] high_bits);
		issue_read(high_bits | ($random(seed) & 32'h3fff_ffff),
			len_t'($unsigned($random(seed)) % 16), cpu_size_t'($random(seed)));
	endtask

	task begin_test(input string name);
		test_name = name;
		err_start = err_cnt;
	endtask

	task finish_test;
		if (err_cnt == err_start) begin
			$display("Test %s: ok", test_name);
			pass_cnt++;
		end else begin
			$display("Test %s: %0d errors", test_name, err_cnt - err_start);
			fail_cnt++;
		end
	endtask

	// Sampled mid-cycle, between the registered edges
	always @(negedge clk) begin
		if (reset_n && cpu_r_valid === 1'b1) begin
			beat_cnt++;
			if (exp_data_q.size() == 0) begin
				$display("ERROR: test %s got a response beat it never asked for", test_name);
				err_cnt++;
			end else begin
				check_val({test_name, " data"}, exp_data_q.pop_front(), cpu_r_data);
				check_val({test_name, " resp"}, exp_resp_q.pop_front(), cpu_r_resp);
				check_val({test_name, " last"}, exp_last_q.pop_front(), cpu_r_last);
			end
		end
	end

	initial begin
		int s;
		int o;
		int sva_fails;
		seed         = SEED;
		clk          = 1'b0;
		reset_n      = 1'b0;
		cpu_ar_valid = 1'b0;
		cpu_id       = '0;
		cpu_addr     = '0;
		cpu_len      = '0;
		cpu_size     = '0;
		delay_en     = 1'b0;
		err_cnt      = 0;
		pass_cnt     = 0;
		fail_cnt     = 0;
		beat_cnt     = 0;
		test_name    = "reset";
		repeat (2) @(posedge clk);
		#1;
		reset_n = 1'b1;

		begin_test("reset");
		check_val("reset cpu_ar_ready", 1, cpu_ar_ready);
		check_val("reset cpu_r_valid", 0, cpu_r_valid);
		check_val("reset axi_ar_valid", 0, ar_valid);
		check_val("reset axi_r_ready", 0, r_ready);
		finish_test();

		begin_test("single_beat");
		for (s = 0; s < 4; s++) begin
			for (o = 0; o < 8; o++) begin
				issue_read(($random(seed) & 32'h3fff_fff8) | o, 8'd0, cpu_size_t'(s));
			end
		end
		finish_test();

		begin_test("burst");
		repeat (8) random_read(32'h0);
		finish_test();

		begin_test("ready_delay");
		delay_en = 1'b1; // Slave now stalls AR and R at random
		repeat (8) random_read(32'h0);
		finish_test();

		begin_test("slverr");
		random_read(32'h8000_0000);
		random_read(32'h0);
		finish_test();

		sva_fails = i_axi_rd_bridge_top.i_axi_rd_bridge_sva.assert_fails;
		$display("Summary: %0d tests ok, %0d tests with errors, %0d assertion failures",
			pass_cnt, fail_cnt, sva_fails);
		if (fail_cnt == 0 && err_cnt == 0 && sva_fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- src.f
axi_rd_pkg.sv
rd_req_if.sv
rd_beat_if.sv
rd_req_latch.sv
axi_ar_r_master.sv
rd_data_align.sv
axi_rd_bridge_top.sv
tb_axi_mem_model.sv
axi_rd_bridge_sva.sv
tb_axi_rd_bridge.sv
